/* tests/core_trace.txt */
// word count, then program words loaded at reset_pc upward
// pair count, then pairs of rd and expected wb_data, all hex
31
00500093 FFD00113 002081B3 40208233   // 0-3 addi addi add sub
004172B3 0040E333 001143B3 00309433   // 4-7 and or xor sll
003154B3 40315533 001125B3 00113633   // 8-11 srl sra slt sltu
FFE12693 FFF0B713 FFF0C793 7F00E813   // 12-15 slti sltiu xori ori
0F017893 01C09913 00415993 4013DA13   // 16-19 andi slli srli srai
00708013 00100AB3 01508663 00100B13   // 20-23 write x0, read x0, beq taken
00200B13 00209663 00300B13 00400B13   // 24-27 bne taken
00114663 00500B13 00600B13 0020D663   // 28-31 blt taken, bge taken
00700B13 00800B13 0020E663 00900B13   // 32-35 bltu taken
00A00B13 00117663 00B00B13 00C00B13   // 36-39 bgeu taken
00208463 01100B13 00116463 001B0B93   // 40-43 beq and bltu not taken
0020C463 00115463 01509463 0020F463   // 44-47 blt bge bne bgeu not taken
800B8C13                              // 48 addi with imm -2048
// expected writebacks
18
01 00000005  02 FFFFFFFD   // positive and negative immediates
03 00000002  04 00000008   // add and sub, forwarded and bypassed
05 00000008  06 0000000D   // and, or
07 FFFFFFF8  08 00000014   // xor, sll
09 3FFFFFFF  0A FFFFFFFF   // srl, sra
0B 00000001  0C 00000000   // slt, sltu
0D 00000001  0E 00000001   // slti, sltiu
0F FFFFFFFA  10 000007F5   // xori, ori
11 000000F0  12 50000000   // andi, slli
13 0FFFFFFF  14 FFFFFFFC   // srli, srai
15 00000005  16 00000011   // x0 read, first write after untaken beq
17 00000012  18 FFFFF812   // dependent chain through untaken branches

/* compile.f */
rtl/core_pkg.sv
rtl/rv_isa_pkg.sv
rtl/fetch_stage.sv
rtl/register_file.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/core_top.sv
tests/core_tb.sv

/* run.sh */
#!/bin/sh
# build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing -j 0 --top-module core_tb -f compile.f -o core_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/core_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Test OK" "$log"; then
    exit 0
fi
echo "pass message not found in $log"
exit 1

/* tests/core_tb.sv */
// Core testbench
module core_tb
    import core_pkg::*;
();

    localparam logic [xlen-1:0] reset_pc     = 32'h0000_0100;   // first fetch address
    localparam int              trace_depth  = 256;
    localparam int              reset_cycles = 16;
    localparam int              drain_cycles = 10;
    localparam logic [31:0]     idle_word    = 32'h0000_0063;   // beq x0, x0, 0

    // DUT ports
    logic            clk;
    logic            reset_b;
    logic [xlen-1:0] imem_addr;
    logic [31:0]     imem_data;
    logic            wb_valid;
    reg_addr_t       wb_rd;
    logic [xlen-1:0] wb_data;

    logic [31:0] trace [0:trace_depth-1];   // raw trace words
    logic [31:0] imem  [0:trace_depth-1];   // program image
    int          prog_words;
    int          exp_count;
    int          exp_base;                  // first rd of the expected pairs
    int          exp_index;                 // next expected writeback

    core_top #(
        .reset_pc  (reset_pc)
    ) DUT (
        .clk       (clk),
        .reset_b   (reset_b),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .wb_valid  (wb_valid),
        .wb_rd     (wb_rd),
        .wb_data   (wb_data)
    );

    always #5 clk = ~clk;   // 10 unit period

    // ----------------------------------------
    // error handling

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("mismatch %s: got %h, expected %h", name, actual, expected));
        end
    endtask

    // ----------------------------------------
    // instruction memory model

    // word at addr, idle loop outside the program
    function automatic logic [31:0] fetch_word(input logic [xlen-1:0] addr);
        logic [xlen-1:0] offset;
        int              index;
        offset = addr - reset_pc;           // wraps high below reset_pc
        index  = int'(offset >> 2);
        if (offset[1:0] != 2'b00 || index >= prog_words) begin
            return idle_word;
        end
        return imem[index];
    endfunction

    always @(negedge clk) begin
        imem_data = fetch_word(imem_addr);  // settles long before the next rise
    end

    // ----------------------------------------
    // writeback monitor, sampled mid cycle
    always @(negedge clk) begin
        if (wb_valid) begin
            if (exp_index >= exp_count) begin
                abort_run("wb_valid was raised after every expected writeback was seen");
            end else begin
                check_value("wb_rd", 32'(wb_rd), trace[exp_base + 2 * exp_index]);
                check_value("wb_data", wb_data, trace[exp_base + 2 * exp_index + 1]);
                exp_index++;
            end
        end
    end

    // ----------------------------------------
    // watchdog, budget grows with the program
    initial begin : watchdog
        int limit;
        @(posedge reset_b);
        limit = prog_words * 3 + 40;
        repeat (limit) @(posedge clk);
        if (exp_index < exp_count) begin
            abort_run($sformatf("timeout, only %0d of %0d writebacks seen after %0d cycles",
                                exp_index, exp_count, limit));
        end
    end

    // ----------------------------------------
    // main sequence
    initial begin
        clk       = 1'b0;
        reset_b   = 1'b0;
        imem_data = idle_word;
        exp_index = 0;

        // word count, program, pair count, pairs
        $readmemh("tests/core_trace.txt", trace);
        if ($isunknown(trace[0]) || trace[0] == 32'd0) begin
            abort_run("trace file tests/core_trace.txt could not be read");
        end
        prog_words = int'(trace[0]);
        exp_count  = int'(trace[prog_words + 1]);
        exp_base   = prog_words + 2;
        if (exp_base + 2 * exp_count > trace_depth) begin
            abort_run("trace file is larger than the trace buffer");
        end
        for (int i = 0; i < prog_words; i++) begin
            imem[i] = trace[i + 1];
        end

        // pc parked, no writebacks while held in reset
        repeat (reset_cycles) begin
            @(negedge clk);
            check_value("imem_addr", imem_addr, reset_pc);
            check_value("wb_valid", 32'(wb_valid), 32'd0);
        end
        reset_b = 1'b1;

        // three cycles of pipeline fill, pc steps by 4
        for (int k = 0; k < 3; k++) begin
            check_value("imem_addr", imem_addr, reset_pc + 32'(4 * k));
            check_value("wb_valid", 32'(wb_valid), 32'd0);
            @(negedge clk);
        end

        wait (exp_index == exp_count);      // watchdog guards this
        repeat (drain_cycles) @(negedge clk);   // catch stray writebacks

        $display("Test OK");
        $finish;
    end

endmodule

/* rtl/core_top.sv */
// Four stage RV32 integer core
module core_top
    import core_pkg::*;
#(
    parameter logic [xlen-1:0] reset_pc = 32'h0000_0000
) (
    input  logic            clk,
    input  logic            reset_b,
    // instruction memory, combinational read
    output logic [xlen-1:0] imem_addr,
    input  logic [31:0]     imem_data,
    // writeback observation
    output logic            wb_valid,
    output reg_addr_t       wb_rd,
    output logic [xlen-1:0] wb_data
);

    logic [xlen-1:0] pc;
    logic            branch_taken;
    logic [xlen-1:0] branch_target;

    // register file read port
    reg_addr_t       rs1_addr;
    reg_addr_t       rs2_addr;
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;

    // ID/EX fields
    logic            ex_valid;
    logic [xlen-1:0] ex_pc;
    reg_addr_t       ex_rs1;
    reg_addr_t       ex_rs2;
    reg_addr_t       ex_rd;
    logic [xlen-1:0] ex_rs1_data;
    logic [xlen-1:0] ex_rs2_data;
    logic [xlen-1:0] ex_imm;
    logic            ex_use_imm;
    logic            ex_use_rs2;
    alu_op_t         ex_alu_op;
    branch_cond_t    ex_branch_cond;
    logic            ex_reg_write;

    assign imem_addr = pc;

    // ----------------------------------------
    fetch_stage #(
        .reset_pc      (reset_pc)
    ) u_fetch (
        .clk           (clk),
        .reset_b       (reset_b),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .pc            (pc)
    );

    decode_stage u_decode (
        .clk            (clk),
        .reset_b        (reset_b),
        .pc             (pc),
        .imem_data      (imem_data),
        .branch_taken   (branch_taken),
        .rs1_addr       (rs1_addr),
        .rs2_addr       (rs2_addr),
        .rs1_data       (rs1_data),
        .rs2_data       (rs2_data),
        .ex_valid       (ex_valid),
        .ex_pc          (ex_pc),
        .ex_rs1         (ex_rs1),
        .ex_rs2         (ex_rs2),
        .ex_rd          (ex_rd),
        .ex_rs1_data    (ex_rs1_data),
        .ex_rs2_data    (ex_rs2_data),
        .ex_imm         (ex_imm),
        .ex_use_imm     (ex_use_imm),
        .ex_use_rs2     (ex_use_rs2),
        .ex_alu_op      (ex_alu_op),
        .ex_branch_cond (ex_branch_cond),
        .ex_reg_write   (ex_reg_write)
    );

    // write port fed straight from the writeback register
    register_file u_regfile (
        .clk      (clk),
        .reset_b  (reset_b),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .wr_en    (wb_valid),
        .wr_addr  (wb_rd),
        .wr_data  (wb_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    execute_stage u_execute (
        .clk            (clk),
        .reset_b        (reset_b),
        .ex_valid       (ex_valid),
        .ex_pc          (ex_pc),
        .ex_rs1         (ex_rs1),
        .ex_rs2         (ex_rs2),
        .ex_rd          (ex_rd),
        .ex_rs1_data    (ex_rs1_data),
        .ex_rs2_data    (ex_rs2_data),
        .ex_imm         (ex_imm),
        .ex_use_imm     (ex_use_imm),
        .ex_use_rs2     (ex_use_rs2),
        .ex_alu_op      (ex_alu_op),
        .ex_branch_cond (ex_branch_cond),
        .ex_reg_write   (ex_reg_write),
        .branch_taken   (branch_taken),
        .branch_target  (branch_target),
        .wb_valid       (wb_valid),
        .wb_rd          (wb_rd),
        .wb_data        (wb_data)
    );

endmodule

/* rtl/execute_stage.sv */
// Execute stage and writeback register
module execute_stage
    import core_pkg::*;
    import rv_isa_pkg::*;
(
    input  logic            clk,
    input  logic            reset_b,
    // ID/EX fields
    input  logic            ex_valid,
    input  logic [xlen-1:0] ex_pc,
    input  reg_addr_t       ex_rs1,
    input  reg_addr_t       ex_rs2,
    input  reg_addr_t       ex_rd,
    input  logic [xlen-1:0] ex_rs1_data,
    input  logic [xlen-1:0] ex_rs2_data,
    input  logic [xlen-1:0] ex_imm,
    input  logic            ex_use_imm,
    input  logic            ex_use_rs2,
    input  alu_op_t         ex_alu_op,
    input  branch_cond_t    ex_branch_cond,
    input  logic            ex_reg_write,
    // redirect to fetch and decode
    output logic            branch_taken,
    output logic [xlen-1:0] branch_target,
    // writeback register
    output logic            wb_valid,
    output reg_addr_t       wb_rd,
    output logic [xlen-1:0] wb_data
);

    logic            fwd_a;
    logic            fwd_b;
    logic [xlen-1:0] rs1_val;       // after forwarding
    logic [xlen-1:0] rs2_val;
    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
    logic [shamt_w-1:0] shamt;
    logic [xlen-1:0] alu_result;
    logic            is_eq;
    logic            is_lt;         // signed
    logic            is_ltu;
    logic            cond_met;

    // ----------------------------------------
    // forwarding from the writeback register
    // distance two is covered by the register file bypass
    assign fwd_a = wb_valid && (wb_rd != '0) && (wb_rd == ex_rs1);
    assign fwd_b = wb_valid && (wb_rd != '0) && (wb_rd == ex_rs2) && ex_use_rs2;

    assign rs1_val = fwd_a ? wb_data : ex_rs1_data;
    assign rs2_val = fwd_b ? wb_data : ex_rs2_data;

    assign op_a  = rs1_val;
    assign op_b  = ex_use_imm ? ex_imm : rs2_val;   // i-type takes the immediate
    assign shamt = op_b[shamt_w-1:0];

    // ----------------------------------------
    // alu
    always_comb begin
        case (ex_alu_op)
            alu_add:  alu_result = op_a + op_b;
            alu_sub:  alu_result = op_a - op_b;
            alu_and:  alu_result = op_a & op_b;
            alu_or:   alu_result = op_a | op_b;
            alu_xor:  alu_result = op_a ^ op_b;
            alu_sll:  alu_result = op_a << shamt;
            alu_srl:  alu_result = op_a >> shamt;
            alu_sra:  alu_result = $unsigned($signed(op_a) >>> shamt);
            alu_slt:  alu_result = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            alu_sltu: alu_result = {{(xlen-1){1'b0}}, op_a < op_b};
            default:  alu_result = op_a + op_b;
        endcase
    end

    // ----------------------------------------
    // branch unit, compares the two register values
    assign is_eq  = (rs1_val == rs2_val);
    assign is_lt  = ($signed(rs1_val) < $signed(rs2_val));
    assign is_ltu = (rs1_val < rs2_val);

    always_comb begin
        case (ex_branch_cond)
            br_eq:   cond_met = is_eq;
            br_ne:   cond_met = !is_eq;
            br_lt:   cond_met = is_lt;
            br_ge:   cond_met = !is_lt;
            br_ltu:  cond_met = is_ltu;
            br_geu:  cond_met = !is_ltu;
            default: cond_met = 1'b0;    // br_none
        endcase
    end

    assign branch_taken  = ex_valid && cond_met;   // bubbles never redirect
    assign branch_target = ex_pc + ex_imm;         // imm already << 1

    // ----------------------------------------
    // writeback register
    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            wb_valid <= 1'b0;
            wb_rd    <= '0;
        end else begin
            wb_valid <= ex_valid && ex_reg_write;   // low for branches and x0
            wb_rd    <= ex_rd;
        end
    end

    always_ff @(posedge clk) begin
        wb_data <= alu_result;
    end

endmodule

/* rtl/decode_stage.sv */
// Decode stage with IF/ID and ID/EX registers
module decode_stage
    import core_pkg::*;
    import rv_isa_pkg::*;
(
    input  logic            clk,
    input  logic            reset_b,
    input  logic [xlen-1:0] pc,
    input  logic [31:0]     imem_data,
    input  logic            branch_taken,   // flush both registers
    // register file read port
    output reg_addr_t       rs1_addr,
    output reg_addr_t       rs2_addr,
    input  logic [xlen-1:0] rs1_data,
    input  logic [xlen-1:0] rs2_data,
    // ID/EX fields
    output logic            ex_valid,
    output logic [xlen-1:0] ex_pc,
    output reg_addr_t       ex_rs1,
    output reg_addr_t       ex_rs2,
    output reg_addr_t       ex_rd,
    output logic [xlen-1:0] ex_rs1_data,
    output logic [xlen-1:0] ex_rs2_data,
    output logic [xlen-1:0] ex_imm,
    output logic            ex_use_imm,
    output logic            ex_use_rs2,
    output alu_op_t         ex_alu_op,
    output branch_cond_t    ex_branch_cond,
    output logic            ex_reg_write
);

    // IF/ID contents
    logic            id_valid;
    logic [xlen-1:0] id_pc;
    logic [31:0]     id_inst;

    // decoded values
    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic            alt;
    reg_addr_t       rd;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_b;
    logic [xlen-1:0] dec_imm;
    logic            dec_valid;
    logic            dec_use_imm;
    logic            dec_use_rs2;
    logic            dec_reg_write;
    alu_op_t         dec_alu_op;
    branch_cond_t    dec_cond;

    // funct3 to alu op, alt only counts for sub on r-type
    function automatic alu_op_t alu_sel(input logic [2:0] f3, input logic alt_bit,
                                        input logic is_reg);
        alu_op_t op;
        case (f3)
            f3_add:  op = (is_reg && alt_bit) ? alu_sub : alu_add;
            f3_sll:  op = alu_sll;
            f3_slt:  op = alu_slt;
            f3_sltu: op = alu_sltu;
            f3_xor:  op = alu_xor;
            f3_srl:  op = alt_bit ? alu_sra : alu_srl;   // srai also uses bit 30
            f3_or:   op = alu_or;
            f3_and:  op = alu_and;
            default: op = alu_add;
        endcase
        return op;
    endfunction

    // ----------------------------------------
    // IF/ID register
    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            id_valid <= 1'b0;
        end else begin
            id_valid <= !branch_taken;   // younger fetch killed on redirect
        end
    end

    always_ff @(posedge clk) begin
        id_pc   <= pc;
        id_inst <= imem_data;
    end

    // field split
    assign opcode   = id_inst[6:0];
    assign funct3   = id_inst[funct3_lsb +: 3];
    assign alt      = id_inst[funct7_alt_bit];
    assign rd       = id_inst[rd_lsb +: reg_field_w];
    assign rs1_addr = id_inst[rs1_lsb +: reg_field_w];
    assign rs2_addr = id_inst[rs2_lsb +: reg_field_w];

    // immediates, b-type already shifted left by one
    assign imm_i = {{20{id_inst[31]}}, id_inst[31:20]};
    assign imm_b = {{19{id_inst[31]}}, id_inst[31], id_inst[7], id_inst[30:25],
                    id_inst[11:8], 1'b0};

    // ----------------------------------------
    // control decode
    always_comb begin
        dec_valid     = 1'b0;      // unknown opcode stays invalid
        dec_use_imm   = 1'b0;
        dec_use_rs2   = 1'b0;
        dec_reg_write = 1'b0;
        dec_alu_op    = alu_add;
        dec_cond      = br_none;
        dec_imm       = imm_i;
        case (opcode)
            op_reg: begin
                dec_valid     = 1'b1;
                dec_use_rs2   = 1'b1;
                dec_reg_write = (rd != '0);          // x0 writes dropped here
                dec_alu_op    = alu_sel(funct3, alt, 1'b1);
            end
            op_imm: begin
                dec_valid     = 1'b1;
                dec_use_imm   = 1'b1;
                dec_reg_write = (rd != '0);
                dec_alu_op    = alu_sel(funct3, alt, 1'b0);
            end
            op_branch: begin
                dec_use_rs2 = 1'b1;                  // compare operand
                dec_imm     = imm_b;                 // target offset
                case (funct3)
                    f3_beq:  dec_cond = br_eq;
                    f3_bne:  dec_cond = br_ne;
                    f3_blt:  dec_cond = br_lt;
                    f3_bge:  dec_cond = br_ge;
                    f3_bltu: dec_cond = br_ltu;
                    f3_bgeu: dec_cond = br_geu;
                    default: dec_cond = br_none;     // 010 / 011 reserved
                endcase
                dec_valid = (dec_cond != br_none);
            end
            default: ;
        endcase
    end

    // ----------------------------------------
    // ID/EX register, control part
    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            ex_valid       <= 1'b0;
            ex_reg_write   <= 1'b0;
            ex_use_imm     <= 1'b0;
            ex_use_rs2     <= 1'b0;
            ex_alu_op      <= alu_add;
            ex_branch_cond <= br_none;
        end else if (branch_taken) begin        // bubble
            ex_valid       <= 1'b0;
            ex_reg_write   <= 1'b0;
            ex_use_imm     <= 1'b0;
            ex_use_rs2     <= 1'b0;
            ex_alu_op      <= alu_add;
            ex_branch_cond <= br_none;
        end else begin
            ex_valid       <= id_valid && dec_valid;
            ex_reg_write   <= id_valid && dec_valid && dec_reg_write;
            ex_use_imm     <= dec_use_imm;
            ex_use_rs2     <= dec_use_rs2;
            ex_alu_op      <= dec_alu_op;
            ex_branch_cond <= dec_cond;
        end
    end

    // payload part, only meaningful when ex_valid
    always_ff @(posedge clk) begin
        ex_pc       <= id_pc;
        ex_rs1      <= rs1_addr;
        ex_rs2      <= rs2_addr;
        ex_rd       <= rd;
        ex_rs1_data <= rs1_data;
        ex_rs2_data <= rs2_data;
        ex_imm      <= dec_imm;
    end

endmodule

/* rtl/register_file.sv */
// Integer register file
module register_file
    import core_pkg::*;
(
    input  logic            clk,
    input  logic            reset_b,
    input  reg_addr_t       rs1_addr,
    input  reg_addr_t       rs2_addr,
    input  logic            wr_en,      // writeback valid
    input  reg_addr_t       wr_addr,
    input  logic [xlen-1:0] wr_data,
    output logic [xlen-1:0] rs1_data,
    output logic [xlen-1:0] rs2_data
);

    logic [xlen-1:0] regs [1:31];   // no storage behind x0
    logic            wr_hit;        // write to a real register

    assign wr_hit = wr_en && (wr_addr != '0);

    // ----------------------------------------
    // write port
    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_hit) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // ----------------------------------------
    // read ports, same-cycle write passes through
    always_comb begin
        if (rs1_addr == '0)                          rs1_data = '0;
        else if (wr_hit && (wr_addr == rs1_addr))    rs1_data = wr_data;
        else                                         rs1_data = regs[rs1_addr];
    end

    always_comb begin
        if (rs2_addr == '0)                          rs2_data = '0;
        else if (wr_hit && (wr_addr == rs2_addr))    rs2_data = wr_data;
        else                                         rs2_data = regs[rs2_addr];
    end

endmodule

/* rtl/fetch_stage.sv */
// Program counter
module fetch_stage
    import core_pkg::*;
#(
    parameter logic [xlen-1:0] reset_pc = 32'h0000_0000   // first fetch address
) (
    input  logic            clk,
    input  logic            reset_b,
    input  logic            branch_taken,    // pulse from execute
    input  logic [xlen-1:0] branch_target,
    output logic [xlen-1:0] pc               // also the imem address
);

    logic [xlen-1:0] pc_plus4;
    logic [xlen-1:0] pc_next;

    // ----------------------------------------
    // next pc select
    assign pc_plus4 = pc + xlen'(4);
    assign pc_next  = branch_taken ? branch_target : pc_plus4;   // redirect wins

    // ----------------------------------------
    // pc register, no stalls so it moves every edge
    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            pc <= reset_pc;
        end else begin
            pc <= pc_next;
        end
    end

endmodule

/* rtl/rv_isa_pkg.sv */
// RV32 integer subset encodings
package rv_isa_pkg;

    // ----------------------------------------
    // major opcodes, inst[6:0]
    localparam logic [6:0] op_reg    = 7'b0110011;   // r-type alu
    localparam logic [6:0] op_imm    = 7'b0010011;   // i-type alu
    localparam logic [6:0] op_branch = 7'b1100011;   // conditional branches

    // ----------------------------------------
    // funct3, alu group
    // sub shares f3_add and sra shares f3_srl, split by funct7_alt_bit
    localparam logic [2:0] f3_add  = 3'b000;
    localparam logic [2:0] f3_sll  = 3'b001;
    localparam logic [2:0] f3_slt  = 3'b010;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_srl  = 3'b101;
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;

    // funct3, branch group
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    // ----------------------------------------
    // field positions
    localparam int funct7_alt_bit = 30;   // sub / sra select
    localparam int rd_lsb         = 7;
    localparam int funct3_lsb     = 12;
    localparam int rs1_lsb        = 15;
    localparam int rs2_lsb        = 20;
    localparam int reg_field_w    = 5;    // width of rd, rs1, rs2
    localparam int shamt_w        = 5;    // shift amount bits used on rv32

endpackage

/* rtl/core_pkg.sv */
// Core internal codes
package core_pkg;

    localparam int xlen = 32;   // data and address width

    typedef logic [4:0] reg_addr_t;   // x0 .. x31

    // alu operations, decoded once in the decode stage
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_slt,
        alu_sltu
    } alu_op_t;

    // branch conditions, br_none for every non-branch
    typedef enum logic [2:0] {
        br_none,
        br_eq,
        br_ne,
        br_lt,
        br_ge,
        br_ltu,
        br_geu
    } branch_cond_t;

endpackage
